// File: Bender.yml
package:
  name: sa_engine

sources:
  - rtl/sa_pkg.sv
  - rtl/sa_ctrl.sv
  - rtl/sa_input_buf.sv
  - rtl/sa_proj_unit.sv
  - rtl/sa_score_unit.sv
  - rtl/sa_out_unit.sv
  - rtl/sa_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_sa.sv

// File: rtl/sa_ctrl.sv
// phase FSM with step counter and latched row count

`timescale 1ns/1ns

module sa_ctrl import sa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  rows_t     t,
	output sa_phase_e phase,
	output step_t     step,
	output rows_t     rows
);

	logic [7:0] cnt;
	logic [7:0] end_cnt;
	logic       start;
	sa_phase_e  next_phase;

	// only T = 1, 4 or 8 starts a burst
	assign start = in_valid && (t inside {rows_t'(1), rows_t'(4), rows_t'(8)});
	assign step = cnt[5:0];

	// last count of the current phase
	always_comb begin
		case (phase)
			ph_load: end_cnt = 8'(load_len - 1);
			ph_out:  end_cnt = {1'b0, rows, 3'b000} - 8'd1;
			default: end_cnt = 8'(phase_len - 1);
		endcase
	end

	always_comb begin
		case (phase)
			ph_load:  next_phase = ph_q;
			ph_q:     next_phase = ph_k;
			ph_k:     next_phase = ph_v;
			ph_v:     next_phase = ph_score;
			ph_score: next_phase = ph_out;
			default:  next_phase = ph_idle;
		endcase
	end

	// the start cycle is load cycle 0, so ph_load itself counts from 1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= ph_idle;
			cnt <= '0;
			rows <= '0;
		end else if (phase == ph_idle) begin
			if (start) begin
				phase <= ph_load;
				cnt <= 8'd1;
				rows <= t;
			end
		end else if (cnt == end_cnt) begin
			phase <= next_phase;
			cnt <= '0;
		end else begin
			cnt <= cnt + 8'd1;
		end
	end

	// the engine never wakes up on its own
	assert property (@(posedge clk) disable iff (!rst_n)
		(phase == ph_idle && !in_valid) |=> (phase == ph_idle));

endmodule

// File: rtl/sa_input_buf.sv
// token and weight storage
// per-step operand select for the projection lanes

`timescale 1ns/1ns

module sa_input_buf import sa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  sa_phase_e phase,
	input  step_t     step,
	input  data_t     in_data,
	input  data_t     w_q,
	input  data_t     w_k,
	input  data_t     w_v,
	output data_t     x_col [dim],
	output data_t     w_elem
);

	// load progress in blocks of 64 cycles
	logic [1:0] blk;
	logic       load_en;
	logic [1:0] rd_sel;
	data_t      w_in;
	data_t      x_mem [dim][dim];
	// Wq, Wk, Wv stacked, all row-major
	data_t      w_mem [3][dim][dim];

	// idle covers load cycle 0 (step stays 0 there)
	assign load_en = (phase == ph_idle) || (phase == ph_load);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blk <= '0;
		end else if (phase != ph_load) begin
			blk <= '0;
		end else if (step == step_t'(phase_len - 1)) begin
			blk <= blk + 2'd1;
		end
	end

	always_comb begin
		case (blk)
			2'd0:    w_in = w_q;
			2'd1:    w_in = w_k;
			default: w_in = w_v;
		endcase
	end

	// X rows past T hold leftover data and the output unit drops their terms
	always_ff @(posedge clk) begin
		if (load_en && blk == 2'd0)
			x_mem[step[5:3]][step[2:0]] <= in_data;
		if (load_en)
			w_mem[blk][step[5:3]][step[2:0]] <= w_in;
	end

	// weight matrix of the running projection
	always_comb begin
		case (phase)
			ph_k:    rd_sel = 2'd1;
			ph_v:    rd_sel = 2'd2;
			default: rd_sel = 2'd0;
		endcase
	end

	// column k of X, element W[k][j] with k = step mod 8, j = step / 8
	always_comb begin
		for (int i = 0; i < dim; i++) begin
			x_col[i] = x_mem[i][step[2:0]];
		end
		w_elem = w_mem[rd_sel][step[2:0]][step[5:3]];
	end

endmodule

// File: rtl/sa_out_unit.sv
// 8-term dot product of a score row and a value column
// registered result with out_valid

`timescale 1ns/1ns

module sa_out_unit import sa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  sa_phase_e phase,
	input  step_t     step,
	input  rows_t     rows,
	input  score_t    s_row [dim],
	input  proj_t     v_col [dim],
	output logic      out_valid,
	output out_t      out_data
);

	out_t term [dim];
	out_t sum;

	// terms past row T are dropped, so unloaded token rows act as zero
	always_comb begin
		for (int k = 0; k < dim; k++) begin
			if (k < int'(rows))
				term[k] = out_t'(s_row[k]) * out_t'(v_col[k]);
			else
				term[k] = '0;
		end
	end

	// balanced adder tree
	assign sum = ((term[0] + term[1]) + (term[2] + term[3]))
		+ ((term[4] + term[5]) + (term[6] + term[7]));

	// one register stage, data held at zero while not valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data <= '0;
		end else if (phase == ph_out) begin
			out_valid <= 1'b1;
			out_data <= sum;
		end else begin
			out_valid <= 1'b0;
			out_data <= '0;
		end
	end

	// every result row comes from an out step inside the loaded rows
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(phase == ph_out) && $past({1'b0, step[5:3]} < rows));

endmodule

// File: rtl/sa_pkg.sv
// shared definitions for the self-attention engine
// matrix size, phase lengths, width typedefs, phase enum

package sa_pkg;

	// ==================================================
	// sizes
	// ==================================================
	// lanes, rows and columns of every matrix
	localparam int dim = 8;
	// one input burst (X, Wq, Wk, Wv)
	localparam int load_len = 192;
	// every compute phase runs one step per matrix element
	localparam int phase_len = 64;

	// ==================================================
	// widths
	// ==================================================
	// step index inside a phase
	typedef logic [5:0] step_t;
	// token and weight elements
	typedef logic signed [7:0] data_t;
	// Q, K, V elements (8 products of 8x8 bits)
	typedef logic signed [18:0] proj_t;
	// raw and scaled scores (8 products of 19x19 bits)
	typedef logic signed [40:0] score_t;
	// result elements
	typedef logic signed [63:0] out_t;
	// number of token rows T
	typedef logic [3:0] rows_t;

	// phase order follows the enum order
	typedef enum logic [2:0] {
		ph_idle, ph_load, ph_q, ph_k, ph_v, ph_score, ph_out
	} sa_phase_e;

endpackage

// File: rtl/sa_proj_unit.sv
// 8-lane projection MAC building Q, K and V
// presents Q and K to the score unit and V to the output unit

`timescale 1ns/1ns

module sa_proj_unit import sa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  sa_phase_e phase,
	input  step_t     step,
	input  data_t     x_col [dim],
	input  data_t     w_elem,
	output proj_t     q_col [dim],
	output proj_t     k_elem,
	output proj_t     v_col [dim]
);

	logic  acc_en;
	logic  elem_last;
	proj_t acc [dim];
	proj_t acc_next [dim];
	// Q, K and V stored as [row][column]
	proj_t q_mem [dim][dim];
	proj_t k_mem [dim][dim];
	proj_t v_mem [dim][dim];

	assign acc_en = (phase == ph_q) || (phase == ph_k) || (phase == ph_v);
	// k = step mod 8 walks the columns of X
	assign elem_last = (step[2:0] == 3'd7);

	// lane i forms X[i][k] * W[k][j]
	always_comb begin
		for (int i = 0; i < dim; i++) begin
			acc_next[i] = acc[i] + proj_t'(x_col[i]) * proj_t'(w_elem);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dim; i++) begin
				acc[i] <= '0;
			end
		end else begin
			for (int i = 0; i < dim; i++) begin
				if (!acc_en || elem_last)
					acc[i] <= '0;
				else
					acc[i] <= acc_next[i];
			end
		end
	end

	// element (i, j) goes to the matrix of the running phase, j = step / 8
	always_ff @(posedge clk) begin
		for (int i = 0; i < dim; i++) begin
			if (elem_last) begin
				case (phase)
					ph_q:    q_mem[i][step[5:3]] <= acc_next[i];
					ph_k:    k_mem[i][step[5:3]] <= acc_next[i];
					ph_v:    v_mem[i][step[5:3]] <= acc_next[i];
					default: ;
				endcase
			end
		end
	end

	// score phase reads Q column k and K[j][k], k = step mod 8, j = step / 8
	// out phase reads V column j = step mod 8
	always_comb begin
		for (int i = 0; i < dim; i++) begin
			q_col[i] = q_mem[i][step[2:0]];
			v_col[i] = v_mem[i][step[2:0]];
		end
		k_elem = k_mem[step[5:3]][step[2:0]];
	end

	// accumulators stay empty outside the projection phases
	assert property (@(posedge clk) disable iff (!rst_n)
		!acc_en |=> (acc[0] == '0 && acc[dim - 1] == '0));

endmodule

// File: rtl/sa_score_unit.sv
// 8-lane Q.K^T accumulation with divide by 3 and ReLU
// holds the score matrix S

`timescale 1ns/1ns

module sa_score_unit import sa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  sa_phase_e phase,
	input  step_t     step,
	input  proj_t     q_col [dim],
	input  proj_t     k_elem,
	output score_t    s_row [dim]
);

	logic   acc_en;
	logic   elem_last;
	score_t acc [dim];
	score_t acc_next [dim];
	score_t scaled [dim];
	score_t s_mem [dim][dim];

	assign acc_en = (phase == ph_score);
	// k = step mod 8 walks the shared dimension of Q and K
	assign elem_last = (step[2:0] == 3'd7);

	// lane i forms Q[i][k] * K[j][k]
	always_comb begin
		for (int i = 0; i < dim; i++) begin
			acc_next[i] = acc[i] + score_t'(q_col[i]) * score_t'(k_elem);
			// signed divide truncates toward zero
			scaled[i] = acc_next[i] / score_t'(3);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dim; i++) begin
				acc[i] <= '0;
			end
		end else begin
			for (int i = 0; i < dim; i++) begin
				if (!acc_en || elem_last)
					acc[i] <= '0;
				else
					acc[i] <= acc_next[i];
			end
		end
	end

	// ReLU then store S[i][j], j = step / 8
	always_ff @(posedge clk) begin
		for (int i = 0; i < dim; i++) begin
			if (acc_en && elem_last)
				s_mem[i][step[5:3]] <= (scaled[i] < 0) ? score_t'(0) : scaled[i];
		end
	end

	// score row i = step / 8 for the output phase
	always_comb begin
		for (int k = 0; k < dim; k++) begin
			s_row[k] = s_mem[step[5:3]][k];
		end
	end

endmodule

// File: rtl/sa_top.sv
// self-attention engine top
// controller, input buffer, projection, score and output units

`timescale 1ns/1ns

module sa_top import sa_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  rows_t t,
	input  data_t in_data,
	input  data_t w_q,
	input  data_t w_k,
	input  data_t w_v,
	output logic  out_valid,
	output out_t  out_data
);

	sa_phase_e phase;
	step_t     step;
	rows_t     rows;
	data_t     x_col [dim];
	data_t     w_elem;
	proj_t     q_col [dim];
	proj_t     k_elem;
	proj_t     v_col [dim];
	score_t    s_row [dim];

	sa_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t(t),
		.phase(phase), .step(step), .rows(rows)
	);

	sa_input_buf u_input_buf (
		.clk(clk), .rst_n(rst_n), .phase(phase), .step(step),
		.in_data(in_data), .w_q(w_q), .w_k(w_k), .w_v(w_v),
		.x_col(x_col), .w_elem(w_elem)
	);

	sa_proj_unit u_proj_unit (
		.clk(clk), .rst_n(rst_n), .phase(phase), .step(step),
		.x_col(x_col), .w_elem(w_elem),
		.q_col(q_col), .k_elem(k_elem), .v_col(v_col)
	);

	sa_score_unit u_score_unit (
		.clk(clk), .rst_n(rst_n), .phase(phase), .step(step),
		.q_col(q_col), .k_elem(k_elem), .s_row(s_row)
	);

	// result stream
	sa_out_unit u_out_unit (
		.clk(clk), .rst_n(rst_n), .phase(phase), .step(step), .rows(rows),
		.s_row(s_row), .v_col(v_col), .out_valid(out_valid), .out_data(out_data)
	);

endmodule

// File: sim/sa_ref_model.svh
// reference model of the self-attention engine
// projection, scaled score and result elements

`ifndef SA_REF_MODEL_SVH
`define SA_REF_MODEL_SVH

// element (i, j) of X.W
function automatic proj_t proj_elem(input data_t x [dim][dim], input data_t w [dim][dim],
	input int i, input int j);
	proj_t acc;
	acc = '0;
	for (int k = 0; k < dim; k++)
		acc += proj_t'(x[i][k]) * proj_t'(w[k][j]);
	return acc;
endfunction

// S[i][j] = ReLU((Q[i] . K[j]) / 3)
function automatic score_t score_elem(input data_t x [dim][dim], input data_t wq [dim][dim],
	input data_t wk [dim][dim], input int i, input int j);
	score_t raw;
	score_t mag;
	raw = '0;
	for (int k = 0; k < dim; k++)
		raw += score_t'(proj_elem(x, wq, i, k)) * score_t'(proj_elem(x, wk, j, k));
	// divide the magnitude, so the quotient truncates toward zero
	mag = (raw < 0) ? -raw : raw;
	mag = mag / 3;
	// negative scores clip to zero
	return (raw < 0) ? score_t'(0) : mag;
endfunction

// A[i][j] = sum over k of S[i][k] * V[k][j]
function automatic out_t result_elem(input data_t x [dim][dim], input data_t wq [dim][dim],
	input data_t wk [dim][dim], input data_t wv [dim][dim], input int i, input int j);
	out_t acc;
	acc = '0;
	for (int k = 0; k < dim; k++)
		acc += out_t'(score_elem(x, wq, wk, i, k)) * out_t'(proj_elem(x, wv, k, j));
	return acc;
endfunction

`endif

// File: sim/tb_sa.sv
// testbench for the self-attention engine
// random, short, ReLU, illegal-start and extreme-value bursts

`timescale 1ns/1ns

module tb_sa import sa_pkg::*; ();

	localparam logic [31:0] seed_init = 32'he64d_4683;
	// cycles allowed for one result burst to start or to end
	localparam int out_timeout = 1000;
	localparam int quiet_cycles = 600;
	localparam int num_random = 3;

	logic  clk = 1'b0;
	logic  rst_n;
	logic  in_valid;
	rows_t t;
	data_t in_data;
	data_t w_q;
	data_t w_k;
	data_t w_v;
	logic  out_valid;
	out_t  out_data;

	logic [31:0] seed;
	// matrices of the running burst, rows of X past T kept zero
	data_t x_m [dim][dim];
	data_t wq_m [dim][dim];
	data_t wk_m [dim][dim];
	data_t wv_m [dim][dim];
	out_t  exp_q [$];
	int    out_cnt = 0;
	logic  seen_valid = 1'b0;

	`include "sa_ref_model.svh"

	sa_top u_dut (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t(t),
		.in_data(in_data), .w_q(w_q), .w_k(w_k), .w_v(w_v),
		.out_valid(out_valid), .out_data(out_data)
	);

	always #5 clk = ~clk;

	// ==================================================
	// random data and error reporting
	// ==================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic data_t rand_data();
		seed = lcg_next(seed);
		return data_t'(seed[23:16]);
	endfunction

	// odd value in 1..127
	function automatic data_t pos_data();
		data_t d;
		d = rand_data();
		return {1'b0, d[6:1], 1'b1};
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		abort_run();
	endtask

	task automatic check_out(input out_t expected, input out_t actual);
		if (actual !== expected) begin
			$display("Fail at %0t ns: out_data expected %0d got %0d", $time, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_rows(input rows_t expected, input rows_t actual);
		if (actual !== expected) begin
			$display("Fail at %0t ns: output rows expected %0d got %0d", $time, expected, actual);
			abort_run();
		end
	endtask

	// ==================================================
	// matrix setup and burst driving
	// ==================================================
	task automatic fill_random(input rows_t rows);
		for (int r = 0; r < dim; r++) begin
			for (int c = 0; c < dim; c++) begin
				x_m[r][c] = (r < int'(rows)) ? rand_data() : data_t'(0);
				wq_m[r][c] = rand_data();
				wk_m[r][c] = rand_data();
				wv_m[r][c] = rand_data();
			end
		end
	endtask

	// every element of a matrix gets the same value, all 8 rows loaded
	task automatic fill_const(input data_t xv, input data_t qv, input data_t kv, input data_t vv);
		for (int r = 0; r < dim; r++) begin
			for (int c = 0; c < dim; c++) begin
				x_m[r][c] = xv;
				wq_m[r][c] = qv;
				wk_m[r][c] = kv;
				wv_m[r][c] = vv;
			end
		end
	endtask

	// X and Wq positive, Wk negative, so Q > 0, K < 0 and every score < 0
	task automatic fill_neg_scores(input rows_t rows);
		for (int r = 0; r < dim; r++) begin
			for (int c = 0; c < dim; c++) begin
				x_m[r][c] = (r < int'(rows)) ? pos_data() : data_t'(0);
				wq_m[r][c] = pos_data();
				wk_m[r][c] = -pos_data();
				wv_m[r][c] = rand_data();
			end
		end
	endtask

	// expected results in row-major order
	task automatic push_expected(input rows_t rows);
		for (int i = 0; i < int'(rows); i++) begin
			for (int j = 0; j < dim; j++)
				exp_q.push_back(result_elem(x_m, wq_m, wk_m, wv_m, i, j));
		end
	endtask

	// 192 cycles of in_valid, fields outside their window carry noise
	task automatic drive_burst(input rows_t rows);
		int row;
		int col;
		for (int c = 0; c < load_len; c++) begin
			@(posedge clk);
			#1;
			row = (c / dim) % dim;
			col = c % dim;
			in_valid = 1'b1;
			t = rows;
			in_data = (c < dim * int'(rows)) ? x_m[row][col] : rand_data();
			w_q = (c < 64) ? wq_m[row][col] : rand_data();
			w_k = (c >= 64 && c < 128) ? wk_m[row][col] : rand_data();
			w_v = (c >= 128) ? wv_m[row][col] : rand_data();
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		t = '0;
	endtask

	// first result, then end of the out_valid run, then its length
	task automatic wait_outputs(input int base, input rows_t rows);
		int waited;
		waited = 0;
		while (out_cnt == base && waited < out_timeout) begin
			@(posedge clk);
			waited++;
		end
		if (out_cnt == base) begin
			report_error("no result burst within the timeout");
		end else begin
			waited = 0;
			while (seen_valid && waited < out_timeout) begin
				@(posedge clk);
				waited++;
			end
			if (seen_valid)
				report_error("result burst did not end within the timeout");
			else
				check_rows(rows, rows_t'((out_cnt - base) / dim));
		end
	endtask

	task automatic run_burst(input rows_t rows);
		int base;
		push_expected(rows);
		base = out_cnt;
		drive_burst(rows);
		wait_outputs(base, rows);
	endtask

	// ==================================================
	// compare process, samples at the falling edge
	// ==================================================
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			seen_valid = out_valid;
			if (out_valid !== 1'b1) begin
				// data stays zero between results
				check_out(out_t'(0), out_data);
			end else if (exp_q.size() == 0) begin
				report_error("out_valid high with no result expected");
			end else begin
				check_out(exp_q.pop_front(), out_data);
				out_cnt++;
			end
		end
	end

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		int base;
		rst_n = 1'b0;
		in_valid = 1'b0;
		t = '0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		w_v = '0;
		seed = seed_init;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// full bursts with random data
		for (int n = 0; n < num_random; n++) begin
			fill_random(rows_t'(8));
			run_burst(rows_t'(8));
		end
		// short bursts, unloaded rows act as zero
		fill_random(rows_t'(1));
		run_burst(rows_t'(1));
		fill_random(rows_t'(4));
		run_burst(rows_t'(4));
		// all scores clipped by ReLU
		fill_neg_scores(rows_t'(4));
		run_burst(rows_t'(4));

		// illegal T stays idle, next legal burst still works
		fill_random(rows_t'(8));
		base = out_cnt;
		drive_burst(rows_t'(3));
		repeat (quiet_cycles) @(posedge clk);
		if (out_cnt != base)
			report_error("output after a start with t = 3");
		fill_random(rows_t'(4));
		run_burst(rows_t'(4));

		// extreme values, one burst after another
		fill_const(-8'sd128, -8'sd128, -8'sd128, -8'sd128);
		run_burst(rows_t'(8));
		fill_const(8'sd127, 8'sd127, 8'sd127, 8'sd127);
		run_burst(rows_t'(8));
		fill_const(8'sd127, -8'sd128, -8'sd128, 8'sd127);
		run_burst(rows_t'(8));

		repeat (20) @(posedge clk);
		$display("All checks passed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+sim
rtl/sa_pkg.sv
rtl/sa_ctrl.sv
rtl/sa_input_buf.sv
rtl/sa_proj_unit.sv
rtl/sa_score_unit.sv
rtl/sa_out_unit.sv
rtl/sa_top.sv
sim/tb_sa.sv
